//--- hdl/rv32f_macros.svh
`ifndef RV32F_MACROS_SVH
`define RV32F_MACROS_SVH

// instruction queue entries, also the credits the core starts with
`define RV32F_QUEUE_DEPTH 4

// wide enough to count 0 through RV32F_QUEUE_DEPTH
`define RV32F_CREDIT_W 3

// architectural fp registers f0..f31
`define RV32F_NREGS 32

`endif

//--- hdl/rv32f_pkg.sv
package rv32f_pkg;

  typedef logic [31:0] word_t;  // data word
  typedef logic [4:0]  freg_t;  // register index

  // major opcodes claimed by the unit
  typedef enum logic [6:0] {
    FPU_OPCODE_LD  = 7'b0000111,  // flw
    FPU_OPCODE_SW  = 7'b0100111,  // fsw
    FPU_OPCODE_ARI = 7'b1010011   // op-fp
  } fpu_opcode_t;

  // funct5 groups of op-fp that are implemented
  typedef enum logic [4:0] {
    FUNCT5_SGNJ   = 5'b00100,
    FUNCT5_MINMAX = 5'b00101,
    FUNCT5_CMP    = 5'b10100,
    FUNCT5_MV_X_W = 5'b11100,
    FUNCT5_MV_W_X = 5'b11110
  } fpu_funct5_t;

  // what execute has to do with a record
  typedef enum logic [3:0] {
    OP_NONE, OP_LOAD, OP_STORE,
    OP_SGNJ, OP_SGNJN, OP_SGNJX,
    OP_MIN, OP_MAX,
    OP_FEQ, OP_FLT, OP_FLE,
    OP_MV_X_W, OP_MV_W_X
  } fpu_op_t;

  // field names follow the load/store view where the formats overlap
  typedef struct packed {
    logic [4:0]  offset_funct5;  // imm[11:7] or funct5
    logic [1:0]  offset_fmt;     // imm[6:5] or fmt
    logic [4:0]  offset_rs2;     // imm[4:0] of flw, else rs2
    logic [4:0]  rs1;
    logic [2:0]  width_rm;       // width for ld/st, rm for op-fp
    logic [4:0]  rd_offset;      // rd, or imm[4:0] of fsw
    fpu_opcode_t opcode;
  } fpu_insn_t;

  typedef struct packed {
    word_t insn;
    word_t rs1_val;  // integer rs1 sampled by the core
  } insn_entry_t;

  typedef struct packed {
    logic        start;  // valid claimed instruction
    fpu_op_t     op;
    logic        load;
    logic        store;
    freg_t       rs1;
    freg_t       rs2;
    freg_t       rd;
    logic [11:0] imm;
    logic [2:0]  frm;
    word_t       rs1_val;
  } decode_execute_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  valid;
    word_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic  valid;
    freg_t rd;    // integer destination
    word_t data;
  } wb_t;

endpackage

//--- hdl/rv32f_insn_queue.sv
`include "rv32f_macros.svh"

module rv32f_insn_queue (
  input  logic                   CLK,
  input  logic                   reset,
  input  logic                   push,
  input  rv32f_pkg::insn_entry_t din,
  input  logic                   pop,
  output rv32f_pkg::insn_entry_t head,
  output logic                   head_valid,
  output logic                   credit_return
);
  import rv32f_pkg::*;

  localparam int PTR_W = $clog2(`RV32F_QUEUE_DEPTH);
  localparam logic [`RV32F_CREDIT_W-1:0] DEPTH_C = `RV32F_QUEUE_DEPTH;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`RV32F_QUEUE_DEPTH - 1);

  insn_entry_t                mem [`RV32F_QUEUE_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [`RV32F_CREDIT_W-1:0] count;  // occupied entries
  logic                       do_pop;

  assign do_pop     = pop && head_valid;
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];  // show-ahead

  always_ff @(posedge CLK) begin
    if (push)
      mem[wr_ptr] <= din;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
      credit_return <= do_pop;  // one pulse per freed entry
    end
  end

  // core spent a credit it did not have
  a_push_not_full: assert property (@(posedge CLK) disable iff (reset)
    push |-> (count < DEPTH_C))
    else $error("insn queue overflow, push without credit");

  a_pop_not_empty: assert property (@(posedge CLK) disable iff (reset)
    pop |-> head_valid)
    else $error("insn queue pop while empty");

endmodule

//--- hdl/rv32f_decode.sv
module rv32f_decode (
  input  logic                       CLK,
  input  logic                       reset,
  input  rv32f_pkg::insn_entry_t     head,
  input  logic                       head_valid,
  input  logic                       ex_ready,
  output logic                       pop,
  output rv32f_pkg::decode_execute_t idex
);
  import rv32f_pkg::*;

  fpu_insn_t       insn;
  decode_execute_t dec;      // record for the queue head
  logic            advance;  // output register free this cycle

  assign insn    = fpu_insn_t'(head.insn);
  assign advance = !idex.start || ex_ready;
  assign pop     = head_valid && advance;  // unclaimed words pop too

  always_comb begin
    dec         = '0;
    dec.op      = OP_NONE;
    dec.frm     = '1;
    dec.rs1     = insn.rs1;  // address base or first operand
    dec.rs1_val = head.rs1_val;
    case (insn.opcode)
      FPU_OPCODE_LD: begin
        if (insn.width_rm == 3'b010) begin  // word width only
          dec.op   = OP_LOAD;
          dec.load = 1'b1;
          dec.rd   = insn.rd_offset;
          dec.imm  = {insn.offset_funct5, insn.offset_fmt, insn.offset_rs2};
        end
      end
      FPU_OPCODE_SW: begin
        if (insn.width_rm == 3'b010) begin
          dec.op    = OP_STORE;
          dec.store = 1'b1;
          dec.rs2   = insn.offset_rs2;  // data register
          dec.imm   = {insn.offset_funct5, insn.offset_fmt, insn.rd_offset};
        end
      end
      FPU_OPCODE_ARI: begin
        dec.rs2 = insn.offset_rs2;
        dec.rd  = insn.rd_offset;
        dec.frm = insn.width_rm;  // carried along, nothing rounds
        if (insn.offset_fmt == 2'b00) begin  // single precision only
          case (insn.offset_funct5)
            FUNCT5_SGNJ: begin
              case (insn.width_rm)
                3'b000:  dec.op = OP_SGNJ;
                3'b001:  dec.op = OP_SGNJN;
                3'b010:  dec.op = OP_SGNJX;
                default: dec.op = OP_NONE;
              endcase
            end
            FUNCT5_MINMAX: begin
              case (insn.width_rm)
                3'b000:  dec.op = OP_MIN;
                3'b001:  dec.op = OP_MAX;
                default: dec.op = OP_NONE;
              endcase
            end
            FUNCT5_CMP: begin
              case (insn.width_rm)
                3'b010:  dec.op = OP_FEQ;
                3'b001:  dec.op = OP_FLT;
                3'b000:  dec.op = OP_FLE;
                default: dec.op = OP_NONE;
              endcase
            end
            FUNCT5_MV_X_W: begin  // rm 001 would be fclass
              if (insn.width_rm == 3'b000 && insn.offset_rs2 == '0)
                dec.op = OP_MV_X_W;
            end
            FUNCT5_MV_W_X: begin
              if (insn.width_rm == 3'b000 && insn.offset_rs2 == '0)
                dec.op = OP_MV_W_X;
            end
            default: dec.op = OP_NONE;
          endcase
        end
      end
      default: dec.op = OP_NONE;  // not ours
    endcase
    dec.start = head_valid && (dec.op != OP_NONE);
  end

  always_ff @(posedge CLK) begin
    if (reset)
      idex <= '0;
    else if (advance)
      idex <= dec;  // start low for empty or discarded heads
  end

endmodule

//--- hdl/rv32f_fregfile.sv
`include "rv32f_macros.svh"

module rv32f_fregfile (
  input  logic             CLK,
  input  logic             reset,
  input  rv32f_pkg::freg_t raddr1,
  input  rv32f_pkg::freg_t raddr2,
  output rv32f_pkg::word_t rdata1,
  output rv32f_pkg::word_t rdata2,
  input  logic             we,
  input  rv32f_pkg::freg_t waddr,
  input  rv32f_pkg::word_t wdata
);
  import rv32f_pkg::*;

  word_t regs [`RV32F_NREGS];

  // reads see the value before a same-cycle write
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < `RV32F_NREGS; i++)
        regs[i] <= '0;
    end else if (we) begin
      regs[waddr] <= wdata;  // f0 is a normal register
    end
  end

endmodule

//--- hdl/rv32f_execute.sv
module rv32f_execute (
  input  logic                       CLK,
  input  logic                       reset,
  input  rv32f_pkg::decode_execute_t idex,
  output logic                       ex_ready,
  output rv32f_pkg::mem_req_t        mem_req,
  input  rv32f_pkg::mem_rsp_t        mem_rsp,
  output rv32f_pkg::wb_t             wb
);
  import rv32f_pkg::*;

  typedef enum logic {EX_IDLE, EX_MEM} ex_state_t;

  ex_state_t state;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     addr;      // rs1_val + sext(imm)
  logic      a_lt_b;    // sign-magnitude order
  logic      a_eq_b;
  logic      accept;
  logic      fwe;
  freg_t     fwaddr;
  word_t     fwdata;
  freg_t     ld_rd;     // load destination while waiting
  wb_t       wb_next;

  rv32f_fregfile i_fregfile (
    .CLK    (CLK),
    .reset  (reset),
    .raddr1 (idex.rs1),
    .raddr2 (idex.rs2),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .we     (fwe),
    .waddr  (fwaddr),
    .wdata  (fwdata)
  );

  assign ex_ready = (state == EX_IDLE);  // stall decode during memory ops
  assign accept   = ex_ready && idex.start;
  assign addr     = idex.rs1_val + {{20{idex.imm[11]}}, idex.imm};

  // -0 sorts below +0, operands assumed non-nan
  always_comb begin
    a_eq_b = (rs1_data == rs2_data);
    if (rs1_data[31] != rs2_data[31])
      a_lt_b = rs1_data[31];  // negative one is smaller
    else if (rs1_data[31])
      a_lt_b = rs1_data[30:0] > rs2_data[30:0];  // both negative
    else
      a_lt_b = rs1_data[30:0] < rs2_data[30:0];
  end

  always_comb begin
    fwe     = 1'b0;
    fwaddr  = idex.rd;
    fwdata  = rs1_data;
    wb_next = '0;
    wb_next.rd = idex.rd;
    if (state == EX_MEM) begin
      fwe    = mem_rsp.valid && !mem_req.write;  // load completes
      fwaddr = ld_rd;
      fwdata = mem_rsp.rdata;
    end else if (idex.start) begin
      case (idex.op)
        OP_SGNJ: begin
          fwe    = 1'b1;
          fwdata = {rs2_data[31], rs1_data[30:0]};
        end
        OP_SGNJN: begin
          fwe    = 1'b1;
          fwdata = {~rs2_data[31], rs1_data[30:0]};
        end
        OP_SGNJX: begin
          fwe    = 1'b1;
          fwdata = {rs1_data[31] ^ rs2_data[31], rs1_data[30:0]};
        end
        OP_MIN: begin
          fwe    = 1'b1;
          fwdata = a_lt_b ? rs1_data : rs2_data;
        end
        OP_MAX: begin
          fwe    = 1'b1;
          fwdata = a_lt_b ? rs2_data : rs1_data;
        end
        OP_MV_W_X: begin
          fwe    = 1'b1;
          fwdata = idex.rs1_val;  // integer bits, no conversion
        end
        OP_FEQ: begin
          wb_next.valid = 1'b1;
          wb_next.data  = {31'b0, a_eq_b};
        end
        OP_FLT: begin
          wb_next.valid = 1'b1;
          wb_next.data  = {31'b0, a_lt_b};
        end
        OP_FLE: begin
          wb_next.valid = 1'b1;
          wb_next.data  = {31'b0, a_lt_b | a_eq_b};
        end
        OP_MV_X_W: begin
          wb_next.valid = 1'b1;
          wb_next.data  = rs1_data;
        end
        default: ;  // load/store handled by the fsm
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state   <= EX_IDLE;
      mem_req <= '0;
      ld_rd   <= '0;
      wb      <= '0;
    end else begin
      wb <= wb_next;  // single-cycle pulse
      case (state)
        EX_IDLE: begin
          if (accept && (idex.load || idex.store)) begin
            state         <= EX_MEM;
            mem_req.valid <= 1'b1;
            mem_req.write <= idex.store;
            mem_req.addr  <= addr;
            mem_req.wdata <= rs2_data;  // store data read at accept
            ld_rd         <= idex.rd;
          end
        end
        EX_MEM: begin
          if (mem_rsp.valid) begin
            state         <= EX_IDLE;
            mem_req.valid <= 1'b0;
          end
        end
        default: state <= EX_IDLE;
      endcase
    end
  end

  // request held steady until its response
  a_mem_req_stable: assert property (@(posedge CLK) disable iff (reset)
    (mem_req.valid && !mem_rsp.valid) |=>
      (mem_req.valid && $stable(mem_req.write) && $stable(mem_req.addr) &&
       $stable(mem_req.wdata)))
    else $error("mem_req changed while waiting for mem_rsp");

endmodule

//--- hdl/rv32f_ext.sv
module rv32f_ext (
  input  logic                   CLK,
  input  logic                   reset,
  input  rv32f_pkg::insn_entry_t insn_in,
  input  logic                   insn_push,
  output logic                   credit_return,
  output rv32f_pkg::mem_req_t    mem_req,
  input  rv32f_pkg::mem_rsp_t    mem_rsp,
  output rv32f_pkg::wb_t         wb
);
  import rv32f_pkg::*;

  insn_entry_t     head;
  logic            head_valid;
  logic            pop;
  logic            ex_ready;
  decode_execute_t idex;  // decode to execute register

  // credit-governed buffer between core and decode
  rv32f_insn_queue i_insn_queue (
    .CLK           (CLK),
    .reset         (reset),
    .push          (insn_push),
    .din           (insn_in),
    .pop           (pop),
    .head          (head),
    .head_valid    (head_valid),
    .credit_return (credit_return)
  );

  rv32f_decode i_decode (
    .CLK        (CLK),
    .reset      (reset),
    .head       (head),
    .head_valid (head_valid),
    .ex_ready   (ex_ready),
    .pop        (pop),
    .idex       (idex)
  );

  // owns the fp register file
  rv32f_execute i_execute (
    .CLK      (CLK),
    .reset    (reset),
    .idex     (idex),
    .ex_ready (ex_ready),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp),
    .wb       (wb)
  );

endmodule

//--- dv/rv32f_clkgen.sv
module rv32f_clkgen #(
  parameter int PERIOD = 4  // time units per clock
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

//--- dv/tb_rv32f_ext.sv
`include "rv32f_macros.svh"

module tb_rv32f_ext;
  import rv32f_pkg::*;

  localparam int PERIOD    = 4;
  localparam int RESET_CYC = 4;
  localparam int N_INSNS   = 64;  // at least the instructions issued below
  localparam int INSN_CYC  = 16;  // queue, decode, slowest memory reply, waits
  localparam int WAIT_CYC  = 48;  // bound for one expected event
  localparam int LOG_N     = 64;

  logic        clk;
  logic        reset;
  insn_entry_t insn_in;
  logic        insn_push;
  logic        credit_return;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp = '0;
  wb_t         wb;

  word_t    mem_words [256];  // indexed by addr[9:2]
  int       lat_min;          // lower bound of reply delay
  int       lat_left;
  logic     req_seen;
  int       credits;          // core view, DEPTH after reset
  int       push_count;
  int       ret_count;
  int       req_count;
  int       wb_count;
  int       store_count;
  wb_t      wb_log [LOG_N];
  mem_req_t store_log [LOG_N];
  int       wb_idx;           // next log entries to consume
  int       store_idx;
  word_t    fshadow [`RV32F_NREGS];  // expected fp register contents

  rv32f_clkgen #(.PERIOD(PERIOD)) i_clkgen (.clk(clk));

  rv32f_ext i_rv32f_ext (
    .CLK           (clk),
    .reset         (reset),
    .insn_in       (insn_in),
    .insn_push     (insn_push),
    .credit_return (credit_return),
    .mem_req       (mem_req),
    .mem_rsp       (mem_rsp),
    .wb            (wb)
  );

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopping simulation");
  endtask

  task automatic check(input string name, input word_t actual, input word_t expected);
    if (actual !== expected)
      fail_now($sformatf("CHECK FAILED at %0t: %s = %h, expected %h",
                         $time, name, actual, expected));
  endtask

  // memory model, one reply per request after 1..4 cycles
  always @(posedge clk) begin : mem_model
    int left;
    if (reset) begin
      mem_rsp     <= '0;
      req_seen    <= 1'b0;
      lat_left    <= 0;
      req_count   <= 0;
      store_count <= 0;
    end else begin
      mem_rsp.valid <= 1'b0;
      if (mem_req.valid && !mem_rsp.valid) begin
        if (req_seen) begin
          left = lat_left - 1;
        end else begin
          left = int'($urandom_range(4, lat_min)) - 1;
          req_count <= req_count + 1;  // new request
        end
        lat_left <= left;
        req_seen <= (left != 0);
        if (left == 0) begin
          mem_rsp.valid <= 1'b1;
          mem_rsp.rdata <= mem_words[mem_req.addr[9:2]];
          if (mem_req.write) begin
            store_log[store_count] <= mem_req;
            store_count            <= store_count + 1;
          end
        end
      end
    end
  end

  // credits, pushes and write-backs as the core sees them
  always @(posedge clk) begin
    if (reset) begin
      credits    <= `RV32F_QUEUE_DEPTH;
      push_count <= 0;
      ret_count  <= 0;
      wb_count   <= 0;
    end else begin
      if (credits < 0 || credits > `RV32F_QUEUE_DEPTH)
        fail_now($sformatf("credit counter out of range at %0t: %0d", $time, credits));
      credits    <= credits - int'(insn_push) + int'(credit_return);
      push_count <= push_count + int'(insn_push);
      ret_count  <= ret_count + int'(credit_return);
      if (wb.valid) begin
        wb_log[wb_count] <= wb;
        wb_count <= wb_count + 1;
      end
    end
  end

  function automatic word_t fill_word(input int idx);
    return {4{idx[7:0]}} ^ 32'h4000_0000;  // differs for every word
  endfunction

  function automatic word_t eff_addr(input word_t base, input logic [11:0] imm);
    return base + word_t'(int'($signed(imm)));
  endfunction

  // rs1 field of loads and stores names x10, its value travels in rs1_val
  function automatic word_t enc_flw(input int rd, input logic [11:0] imm);
    return {imm, 5'd10, 3'b010, rd[4:0], 7'b0000111};
  endfunction

  function automatic word_t enc_fsw(input int rs2, input logic [11:0] imm);
    return {imm[11:5], rs2[4:0], 5'd10, 3'b010, imm[4:0], 7'b0100111};
  endfunction

  function automatic word_t enc_opfp(input logic [4:0] funct5, input logic [2:0] rm,
                                     input int rs2, input int rs1, input int rd);
    return {funct5, 2'b00, rs2[4:0], rs1[4:0], rm, rd[4:0], 7'b1010011};
  endfunction

  // bigger key, bigger number; -0 sits just below +0
  function automatic word_t order_key(input word_t f);
    return f[31] ? ~f : (f | 32'h8000_0000);
  endfunction

  function automatic logic fp_less(input word_t a, input word_t b);
    return order_key(a) < order_key(b);
  endfunction

  task automatic send_insn(input word_t insn, input word_t rs1_val);
    @(posedge clk);
    while (credits - int'(insn_push) <= 0) begin  // out of credits, hold off
      insn_push <= 1'b0;
      @(posedge clk);
    end
    insn_in.insn    <= insn;
    insn_in.rs1_val <= rs1_val;
    insn_push       <= 1'b1;
  endtask

  task automatic stop_push();
    @(posedge clk);
    insn_push <= 1'b0;
  endtask

  task automatic expect_wb(input int rd, input word_t data, input string what);
    int waited;
    waited = 0;
    stop_push();
    while (wb_count <= wb_idx) begin
      if (waited == WAIT_CYC)
        fail_now($sformatf("no write-back for %s within %0d cycles", what, WAIT_CYC));
      waited++;
      @(posedge clk);
    end
    check({what, " wb.rd"}, word_t'(wb_log[wb_idx].rd), word_t'(rd));
    check({what, " wb.data"}, wb_log[wb_idx].data, data);
    wb_idx++;
  endtask

  task automatic expect_store(input word_t addr, input word_t data, input string what);
    int waited;
    waited = 0;
    stop_push();
    while (store_count <= store_idx) begin
      if (waited == WAIT_CYC)
        fail_now($sformatf("no store request for %s within %0d cycles", what, WAIT_CYC));
      waited++;
      @(posedge clk);
    end
    check({what, " mem_req.addr"}, store_log[store_idx].addr, addr);
    check({what, " mem_req.wdata"}, store_log[store_idx].wdata, data);
    store_idx++;
  endtask

  task automatic drain_credits(input string what);
    int waited;
    waited = 0;
    stop_push();
    @(posedge clk);  // let the last push reach the counters
    while (ret_count < push_count) begin
      if (waited == WAIT_CYC)
        fail_now($sformatf("credits not returned after %s", what));
      waited++;
      @(posedge clk);
    end
    check({what, " credit returns"}, word_t'(ret_count), word_t'(push_count));
  endtask

  task automatic load(input int rd, input word_t base, input logic [11:0] imm);
    word_t a;
    a = eff_addr(base, imm);
    send_insn(enc_flw(rd, imm), base);
    fshadow[rd] = mem_words[a[9:2]];
  endtask

  task automatic store_check(input int rs2, input word_t base, input logic [11:0] imm,
                             input string what);
    send_insn(enc_fsw(rs2, imm), base);
    expect_store(eff_addr(base, imm), fshadow[rs2], what);
  endtask

  task automatic sign_inject(input logic [2:0] rm, input int rd, input int rs1, input int rs2);
    logic s;
    case (rm)
      3'b000:  s = fshadow[rs2][31];
      3'b001:  s = !fshadow[rs2][31];
      default: s = fshadow[rs1][31] ^ fshadow[rs2][31];
    endcase
    send_insn(enc_opfp(5'b00100, rm, rs2, rs1, rd), '0);
    fshadow[rd] = {s, fshadow[rs1][30:0]};
  endtask

  task automatic min_max(input logic is_max, input int rd, input int rs1, input int rs2);
    word_t a;
    word_t b;
    a = fshadow[rs1];
    b = fshadow[rs2];
    send_insn(enc_opfp(5'b00101, {2'b00, is_max}, rs2, rs1, rd), '0);
    if (is_max)
      fshadow[rd] = fp_less(a, b) ? b : a;
    else
      fshadow[rd] = fp_less(b, a) ? b : a;
  endtask

  task automatic compare(input logic [2:0] rm, input int rd, input int rs1, input int rs2);
    word_t a;
    logic  res;
    a = fshadow[rs1];
    case (rm)
      3'b010:  res = (a == fshadow[rs2]);  // feq
      3'b001:  res = fp_less(a, fshadow[rs2]);  // flt
      default: res = !fp_less(fshadow[rs2], a);  // fle
    endcase
    send_insn(enc_opfp(5'b10100, rm, rs2, rs1, rd), '0);
    expect_wb(rd, word_t'(res), $sformatf("compare rm=%0d f%0d f%0d", rm, rs1, rs2));
  endtask

  task automatic move_in(input int rd, input word_t val);
    send_insn(enc_opfp(5'b11110, 3'b000, 0, 11, rd), val);
    fshadow[rd] = val;
  endtask

  task automatic move_out(input int rd, input int rs1);
    send_insn(enc_opfp(5'b11100, 3'b000, 0, rs1, rd), '0);
    expect_wb(rd, fshadow[rs1], $sformatf("fmv.x.w from f%0d", rs1));
  endtask

  task automatic load_store_test();
    load(1, 32'h0000_0100, 12'h010);
    load(2, 32'h0000_0100, 12'hff8);  // negative offset
    load(3, 32'h0000_0200, 12'h0a4);
    load(4, 32'h0000_0300, 12'h03c);
    load(5, 32'h0000_03a0, 12'h040);
    store_check(1, 32'h0000_1000, 12'h1a4, "fsw f1");  // high imm bits set
    store_check(2, 32'h0000_2000, 12'h800, "fsw f2");  // most negative offset
    store_check(3, 32'h0000_0500, 12'h7fc, "fsw f3");
    store_check(4, 32'h0000_4000, 12'hfe0, "fsw f4");
    store_check(5, 32'h0000_0000, 12'h014, "fsw f5");
  endtask

  task automatic sign_inject_test();
    sign_inject(3'b000, 6, 1, 2);
    store_check(6, 32'h0000_0600, 12'h000, "fsgnj");
    sign_inject(3'b001, 7, 1, 2);
    store_check(7, 32'h0000_0600, 12'h004, "fsgnjn");
    sign_inject(3'b010, 8, 2, 5);  // two negatives give a positive
    store_check(8, 32'h0000_0600, 12'h008, "fsgnjx");
    sign_inject(3'b010, 9, 3, 3);
    store_check(9, 32'h0000_0600, 12'h00c, "fsgnjx zero");
  endtask

  task automatic compare_minmax_test();
    compare(3'b010, 10, 1, 1);
    compare(3'b001, 11, 2, 1);
    compare(3'b000, 12, 1, 2);
    compare(3'b001, 13, 3, 4);  // -0 vs +0
    compare(3'b010, 14, 3, 4);
    compare(3'b000, 15, 4, 3);
    compare(3'b000, 16, 5, 5);
    min_max(1'b0, 10, 3, 4);
    move_out(17, 10);
    min_max(1'b1, 11, 3, 4);
    move_out(18, 11);
    min_max(1'b0, 12, 2, 5);
    move_out(19, 12);
    min_max(1'b1, 13, 5, 2);
    move_out(20, 13);
  endtask

  task automatic move_test();
    move_in(14, 32'h1234_5678);
    move_out(7, 14);
    move_in(15, 32'h8000_0001);
    move_out(31, 15);
  endtask

  // more loads than credits, slow replies stall decode
  task automatic burst_test();
    int k;
    lat_min = 4;
    for (k = 0; k < 8; k++)
      load(16 + k, 32'h0000_0800 + word_t'(64 * k), 12'h004);
    for (k = 0; k < 8; k++)
      send_insn(enc_opfp(5'b11100, 3'b000, 0, 16 + k, k + 1), '0);
    for (k = 0; k < 8; k++)
      expect_wb(k + 1, fshadow[16 + k], $sformatf("burst result %0d", k));
    drain_credits("burst");
    lat_min = 1;
  endtask

  task automatic unclaimed_test();
    int reqs;
    int wbs;
    int rets;
    drain_credits("before unclaimed");
    reqs = req_count;
    wbs  = wb_count;
    rets = ret_count;
    send_insn(32'h0010_0093, 32'hdead_beef);  // addi x1, x0, 1
    send_insn(enc_opfp(5'b00000, 3'b000, 2, 1, 3), '0);  // fadd, not implemented
    move_out(9, 1);
    check("mem_req count", word_t'(req_count), word_t'(reqs));
    check("wb count", word_t'(wb_count), word_t'(wbs + 1));
    // both discarded words gave their credit back before the move result
    check("unclaimed credit returns", word_t'(ret_count >= rets + 2), word_t'(1));
    drain_credits("unclaimed");
  endtask

  initial begin
    #((RESET_CYC + N_INSNS * INSN_CYC) * PERIOD);
    fail_now("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(32'h9a66_68f1));
    reset     = 1'b1;
    insn_in   = '0;
    insn_push = 1'b0;
    lat_min   = 1;
    wb_idx    = 0;
    store_idx = 0;
    for (int i = 0; i < 256; i++)
      mem_words[i] = fill_word(i);
    for (int i = 0; i < `RV32F_NREGS; i++)
      fshadow[i] = '0;  // register file clears on reset
    mem_words['h110 / 4] = 32'h3fc0_0000;  // 1.5
    mem_words['h0f8 / 4] = 32'hc020_0000;  // -2.5
    mem_words['h2a4 / 4] = 32'h8000_0000;  // -0
    mem_words['h33c / 4] = 32'h0000_0000;  // +0
    mem_words['h3e0 / 4] = 32'hbfc0_0000;  // -1.5
    repeat (RESET_CYC) @(posedge clk);
    reset <= 1'b0;
    load_store_test();
    sign_inject_test();
    compare_minmax_test();
    move_test();
    burst_test();
    unclaimed_test();
    drain_credits("end of run");
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+hdl
hdl/rv32f_pkg.sv
hdl/rv32f_insn_queue.sv
hdl/rv32f_decode.sv
hdl/rv32f_fregfile.sv
hdl/rv32f_execute.sv
hdl/rv32f_ext.sv
dv/rv32f_clkgen.sv
dv/tb_rv32f_ext.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv32f_ext \
  -f sim.f -o tb_rv32f_ext
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv32f_ext > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$log"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1
